// File: hw/mem_bus_pkg.sv
// memory bus definitions shared by the data cache and the memory side
// bus commands, transaction tags, byte address and line data widths

package mem_bus_pkg;

    ////////////////////////////////////////////////////////////////////
    // address geometry
    ////////////////////////////////////////////////////////////////////

    // byte offset inside one 64-bit line
    localparam int line_offset_bits = 3;

    // only the low 16 address bits reach real memory
    localparam int mem_addr_bits = 16;

    ////////////////////////////////////////////////////////////////////
    // bus types
    ////////////////////////////////////////////////////////////////////

    // command driven towards memory
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // transaction tag handed out by memory
    // zero is the sentinel for no transaction
    typedef logic [3:0] mem_tag_t;

    // full byte address from the core
    typedef logic [31:0] addr_t;

    // one cache line of data
    typedef logic [63:0] line_data_t;

endpackage

// File: hw/dcache_pkg.sv
// data cache geometry
// line count, index and cache tag widths with their field types

package dcache_pkg;

    // direct mapped, one line per index
    localparam int cache_lines = 32;

    // index width follows the line count
    localparam int index_bits = $clog2(cache_lines);

    // whatever is left of the significant address above index and offset
    localparam int cache_tag_bits = mem_bus_pkg::mem_addr_bits
                                  - mem_bus_pkg::line_offset_bits
                                  - index_bits;

    ////////////////////////////////////////////////////////////////////
    // address fields
    ////////////////////////////////////////////////////////////////////

    // selects one line of the array
    typedef logic [index_bits-1:0] line_index_t;

    // cache tag, not to be confused with the memory transaction tag
    typedef logic [cache_tag_bits-1:0] cache_tag_t;

endpackage

// File: hw/dcache_request_select.sv
// request select for the data cache
// folds the load and store strobes into one command, address and data

`timescale 1ns/1ps

module dcache_request_select (
    input  logic                     clock,
    input  logic                     reset,

    // store side of the core
    input  logic                     store_en,
    input  mem_bus_pkg::addr_t       store_addr,
    input  mem_bus_pkg::line_data_t  store_data,

    // load side of the core
    input  logic                     load_en,
    input  mem_bus_pkg::addr_t       load_addr,

    // merged request
    output mem_bus_pkg::bus_command_t req_command,
    output mem_bus_pkg::addr_t       req_addr,
    output mem_bus_pkg::line_data_t  req_data
);

    // store wins, then load, otherwise idle
    always_comb begin
        req_command = mem_bus_pkg::bus_none;
        req_addr    = '0;
        req_data    = '0;
        if (store_en) begin
            req_command = mem_bus_pkg::bus_store;
            req_addr    = store_addr;
            req_data    = store_data;
        end else if (load_en) begin
            // loads carry no data
            req_command = mem_bus_pkg::bus_load;
            req_addr    = load_addr;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // core protocol check
    ////////////////////////////////////////////////////////////////////

    // the core only ever raises one strobe per cycle
    // a collision would silently drop the load
    strobe_exclusive_a: assert property (
        @(posedge clock) disable iff (reset) !(store_en && load_en)
    );

endmodule

// File: hw/dcache_line_store.sv
// line array of the data cache
// valid bits and cache tags per line, hit detection, store write and miss fill

`timescale 1ns/1ps

module dcache_line_store (
    input  logic                      clock,
    input  logic                      reset,

    // merged request from the select stage
    input  mem_bus_pkg::bus_command_t req_command,
    input  mem_bus_pkg::addr_t        req_addr,
    input  mem_bus_pkg::line_data_t   req_data,

    // miss fill from the tracker
    input  logic                      fill,
    input  mem_bus_pkg::line_data_t   mem_data,

    // decoded address fields
    output dcache_pkg::line_index_t   req_index,
    output dcache_pkg::cache_tag_t    req_tag,

    // towards the core
    output logic                      hit,
    output mem_bus_pkg::line_data_t   load_data
);

    ////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////

    mem_bus_pkg::line_data_t data_array  [dcache_pkg::cache_lines];
    dcache_pkg::cache_tag_t  tag_array   [dcache_pkg::cache_lines];
    logic                    valid_array [dcache_pkg::cache_lines];

    // line written this cycle, either by a store or by a fill
    logic                    line_write;
    mem_bus_pkg::line_data_t line_write_data;

    // address split
    // offset | index | tag, bits above the tag are ignored
    assign req_index = req_addr[mem_bus_pkg::line_offset_bits +: dcache_pkg::index_bits];
    assign req_tag   = req_addr[mem_bus_pkg::line_offset_bits + dcache_pkg::index_bits
                                +: dcache_pkg::cache_tag_bits];

    // hit only counts for loads
    // a store never asks for data back
    assign hit = (req_command == mem_bus_pkg::bus_load)
              && valid_array[req_index]
              && (tag_array[req_index] == req_tag);

    // data is read straight out of the array in the same cycle
    assign load_data = data_array[req_index];

    // store data has priority, fill brings in the memory line
    assign line_write      = (req_command == mem_bus_pkg::bus_store) || fill;
    assign line_write_data = (req_command == mem_bus_pkg::bus_store) ? req_data : mem_data;

    ////////////////////////////////////////////////////////////////////
    // array update
    ////////////////////////////////////////////////////////////////////

    // valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < dcache_pkg::cache_lines; i++) begin
                valid_array[i] <= 1'b0;
            end
        end else if (line_write) begin
            valid_array[req_index] <= 1'b1;
        end
    end

    // line payload and tag
    always_ff @(posedge clock) begin
        if (line_write) begin
            data_array[req_index] <= line_write_data;
            tag_array[req_index]  <= req_tag;
        end
    end

    // the tracker must never return a fill while the core stores
    // both would target the same line in one edge
    fill_store_exclusive_a: assert property (
        @(posedge clock) disable iff (reset)
            !(fill && (req_command == mem_bus_pkg::bus_store))
    );

endmodule

// File: hw/dcache_miss_tracker.sv
// miss tracker of the data cache
// last address register, held memory tag, fill detection and bus outputs

`timescale 1ns/1ps

module dcache_miss_tracker (
    input  logic                      clock,
    input  logic                      reset,

    // current request
    input  mem_bus_pkg::bus_command_t req_command,
    input  dcache_pkg::line_index_t   req_index,
    input  dcache_pkg::cache_tag_t    req_tag,
    input  mem_bus_pkg::addr_t        req_addr,
    input  mem_bus_pkg::line_data_t   req_data,
    input  logic                      hit,

    // memory answers
    input  mem_bus_pkg::mem_tag_t     mem_response,
    input  mem_bus_pkg::mem_tag_t     mem_tag,

    // fill strobe to the line array
    output logic                      fill,

    // memory bus
    output mem_bus_pkg::bus_command_t mem_command,
    output mem_bus_pkg::addr_t        mem_addr,
    output mem_bus_pkg::line_data_t   mem_write_data
);

    dcache_pkg::line_index_t last_index;
    dcache_pkg::cache_tag_t  last_tag;
    mem_bus_pkg::mem_tag_t   held_tag;

    logic changed_addr;
    logic tag_capture;

    assign changed_addr = (req_index != last_index) || (req_tag != last_tag);

    // stale tags never fill, even in the cycle the address moves away
    assign fill = (held_tag != '0) && (mem_tag == held_tag) && !changed_addr;

    // re-arm on a move, after a fill, and on every cycle without a tag
    // so a refused request is simply sent again
    assign tag_capture = changed_addr || fill || (held_tag == '0);

    ////////////////////////////////////////////////////////////////////
    // bus outputs
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_command = mem_bus_pkg::bus_none;
        if (req_command == mem_bus_pkg::bus_store) begin
            mem_command = mem_bus_pkg::bus_store;
        end else if ((req_command == mem_bus_pkg::bus_load) && !hit &&
                     ((held_tag == '0) || changed_addr)) begin
            mem_command = mem_bus_pkg::bus_load;
        end
    end

    // line aligned address, store data only for stores
    assign mem_addr = {req_addr[31:mem_bus_pkg::line_offset_bits],
                       {mem_bus_pkg::line_offset_bits{1'b0}}};
    assign mem_write_data = (req_command == mem_bus_pkg::bus_store) ? req_data : '0;

    // all ones after reset so the first request counts as a change
    always_ff @(posedge clock) begin
        if (reset) begin
            last_index <= '1;
            last_tag   <= '1;
            held_tag   <= '0;
        end else begin
            last_index <= req_index;
            last_tag   <= req_tag;
            // only a load response is a tag worth waiting on
            if (tag_capture) begin
                held_tag <= (mem_command == mem_bus_pkg::bus_load) ? mem_response : '0;
            end
        end
    end

    // a fill lands in the line of the load that is still being held
    fill_needs_load_a: assert property (
        @(posedge clock) disable iff (reset)
            fill |-> (req_command == mem_bus_pkg::bus_load)
    );

endmodule

// File: hw/dcache_top.sv
// top level of the write-through data cache
// request select, line array and miss tracker wired to core and memory

`timescale 1ns/1ps

module dcache_top (
    input  logic                      clock,
    input  logic                      reset,

    // core store port
    input  logic                      store_en,
    input  mem_bus_pkg::addr_t        store_addr,
    input  mem_bus_pkg::line_data_t   store_data,

    // core load port
    input  logic                      load_en,
    input  mem_bus_pkg::addr_t        load_addr,
    output mem_bus_pkg::line_data_t   load_data,
    output logic                      load_valid,

    // memory side
    input  mem_bus_pkg::mem_tag_t     mem_response,
    input  mem_bus_pkg::line_data_t   mem_data,
    input  mem_bus_pkg::mem_tag_t     mem_tag,
    output mem_bus_pkg::bus_command_t mem_command,
    output mem_bus_pkg::addr_t        mem_addr,
    output mem_bus_pkg::line_data_t   mem_write_data
);

    // merged request
    mem_bus_pkg::bus_command_t req_command;
    mem_bus_pkg::addr_t        req_addr;
    mem_bus_pkg::line_data_t   req_data;

    // decoded fields and fill strobe
    dcache_pkg::line_index_t   req_index;
    dcache_pkg::cache_tag_t    req_tag;
    logic                      fill;

    dcache_request_select select_i (
        .clock       (clock),
        .reset       (reset),
        .store_en    (store_en),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .req_command (req_command),
        .req_addr    (req_addr),
        .req_data    (req_data)
    );

    // load hit doubles as load_valid towards the core
    dcache_line_store line_store_i (
        .clock       (clock),
        .reset       (reset),
        .req_command (req_command),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .fill        (fill),
        .mem_data    (mem_data),
        .req_index   (req_index),
        .req_tag     (req_tag),
        .hit         (load_valid),
        .load_data   (load_data)
    );

    dcache_miss_tracker tracker_i (
        .clock          (clock),
        .reset          (reset),
        .req_command    (req_command),
        .req_index      (req_index),
        .req_tag        (req_tag),
        .req_addr       (req_addr),
        .req_data       (req_data),
        .hit            (load_valid),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .fill           (fill),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data)
    );

endmodule

// File: verification/dcache_mem_model.sv
// tagged memory model for the data cache testbench
// line store, random refusals, fixed delay returns and write handling

`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int return_delay = 4,
    parameter int random_seed  = 1
) (
    input  logic                      clock,
    input  logic                      reset,
    // share of load requests turned away, in percent
    input  int                        refuse_percent,
    input  mem_bus_pkg::bus_command_t mem_command,
    input  mem_bus_pkg::addr_t        mem_addr,
    input  mem_bus_pkg::line_data_t   mem_write_data,
    output mem_bus_pkg::mem_tag_t     mem_response,
    output mem_bus_pkg::line_data_t   mem_data,
    output mem_bus_pkg::mem_tag_t     mem_tag
);

    localparam int sel_bits   = mem_bus_pkg::mem_addr_bits - mem_bus_pkg::line_offset_bits;
    localparam int line_count = 1 << sel_bits;

    // 64K bytes as 8K lines
    mem_bus_pkg::line_data_t lines [line_count];
    logic [sel_bits-1:0]     line_sel;

    int                      seed;
    int unsigned             roll;
    int                      cycle_count;
    logic                    accept;
    mem_bus_pkg::mem_tag_t   next_tag;

    // accepted loads in flight, oldest first
    mem_bus_pkg::mem_tag_t   pend_tag  [$];
    mem_bus_pkg::line_data_t pend_data [$];
    int                      pend_due  [$];

    // spread over the whole line address
    function automatic mem_bus_pkg::line_data_t line_pattern(int unsigned line);
        return {32'h9e37_79b1 * line, line ^ 32'h0bad_cafe};
    endfunction

    assign line_sel = mem_addr[mem_bus_pkg::mem_addr_bits-1:mem_bus_pkg::line_offset_bits];

    // accept decision is rolled one cycle ahead, the tag shows up with the request
    assign mem_response = (mem_command == mem_bus_pkg::bus_load && accept) ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < line_count; i++) begin
                lines[i] = line_pattern(i);
            end
            seed        = random_seed;
            cycle_count = 0;
            pend_tag.delete();
            pend_data.delete();
            pend_due.delete();
            accept   <= 1'b0;
            next_tag <= 4'd1;
            mem_tag  <= '0;
            mem_data <= '0;
        end else begin
            cycle_count = cycle_count + 1;
            // stores land directly in the line store
            if (mem_command == mem_bus_pkg::bus_store) begin
                lines[line_sel] = mem_write_data;
            end
            // accepted load, data is read now and returned later
            if (mem_response != '0) begin
                pend_tag.push_back(mem_response);
                pend_data.push_back(lines[line_sel]);
                pend_due.push_back(cycle_count + return_delay);
                // tags rotate 1 to 15, zero stays reserved
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            mem_tag <= '0;
            if (pend_due.size() > 0 && pend_due[0] == cycle_count) begin
                void'(pend_due.pop_front());
                mem_tag  <= pend_tag.pop_front();
                mem_data <= pend_data.pop_front();
            end
            roll = $random(seed);
            accept <= (roll % 100) >= refuse_percent;
        end
    end

endmodule

// File: verification/dcache_tb.sv
// testbench for the write-through data cache
// clock and reset, directed and random loads and stores, shadow model, checks

`timescale 1ns/1ps

module dcache_tb;

    localparam int clock_period = 20;
    localparam int reset_cycles = 16;
    localparam int return_delay = 5;
    localparam int random_seed  = 32'h6267;
    localparam int wait_limit   = 300;
    localparam int mem_lines    = 1 << (mem_bus_pkg::mem_addr_bits
                                        - mem_bus_pkg::line_offset_bits);

    logic                      clock;
    logic                      reset;
    logic                      store_en;
    mem_bus_pkg::addr_t        store_addr;
    mem_bus_pkg::line_data_t   store_data;
    logic                      load_en;
    mem_bus_pkg::addr_t        load_addr;
    mem_bus_pkg::line_data_t   load_data;
    logic                      load_valid;
    mem_bus_pkg::mem_tag_t     mem_response;
    mem_bus_pkg::line_data_t   mem_data;
    mem_bus_pkg::mem_tag_t     mem_tag;
    mem_bus_pkg::bus_command_t mem_command;
    mem_bus_pkg::addr_t        mem_addr;
    mem_bus_pkg::line_data_t   mem_write_data;
    int                        refuse_percent;

    // shadow of memory contents and of the cache directory
    mem_bus_pkg::line_data_t   shadow_mem   [mem_lines];
    logic                      shadow_valid [dcache_pkg::cache_lines];
    dcache_pkg::cache_tag_t    shadow_tag   [dcache_pkg::cache_lines];

    // bus checks queued by the stimulus and drained by the compare process
    string                     pend_names    [$];
    logic [63:0]               pend_expected [$];
    logic [63:0]               pend_actual   [$];

    string                     test_name;
    int                        seed;
    int                        check_count;
    int                        error_count;
    int                        timeout_count;
    mem_bus_pkg::addr_t        rand_addr;

    dcache_top dut_i (
        .clock          (clock),
        .reset          (reset),
        .store_en       (store_en),
        .store_addr     (store_addr),
        .store_data     (store_data),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .load_valid     (load_valid),
        .mem_response   (mem_response),
        .mem_data       (mem_data),
        .mem_tag        (mem_tag),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data)
    );

    dcache_mem_model #(
        .return_delay (return_delay),
        .random_seed  (random_seed)
    ) mem_i (
        .clock          (clock),
        .reset          (reset),
        .refuse_percent (refuse_percent),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data),
        .mem_response   (mem_response),
        .mem_data       (mem_data),
        .mem_tag        (mem_tag)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // same fill rule as the memory model
    function automatic mem_bus_pkg::line_data_t line_pattern(int unsigned line);
        return {32'h9e37_79b1 * line, line ^ 32'h0bad_cafe};
    endfunction

    function automatic dcache_pkg::line_index_t index_of(mem_bus_pkg::addr_t addr);
        return addr[mem_bus_pkg::line_offset_bits +: dcache_pkg::index_bits];
    endfunction

    function automatic dcache_pkg::cache_tag_t tag_of(mem_bus_pkg::addr_t addr);
        return addr[mem_bus_pkg::line_offset_bits + dcache_pkg::index_bits
                    +: dcache_pkg::cache_tag_bits];
    endfunction

    // line a load of this address must return
    function automatic mem_bus_pkg::line_data_t expected_line(mem_bus_pkg::addr_t addr);
        return shadow_mem[addr[mem_bus_pkg::mem_addr_bits-1:mem_bus_pkg::line_offset_bits]];
    endfunction

    function automatic logic predict_hit(mem_bus_pkg::addr_t addr);
        return shadow_valid[index_of(addr)] && (shadow_tag[index_of(addr)] == tag_of(addr));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic queue_check(string name, logic [63:0] expected, logic [63:0] actual);
        pend_names.push_back(name);
        pend_expected.push_back(expected);
        pend_actual.push_back(actual);
    endtask

    // every returned line against the shadow memory and then the queued bus checks
    always @(posedge clock) begin
        if (!reset && load_en && load_valid) begin
            check_value({test_name, " data"}, expected_line(load_addr), load_data);
        end
        while (pend_names.size() > 0) begin
            check_value(pend_names.pop_front(), pend_expected.pop_front(),
                        pend_actual.pop_front());
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // one store cycle with the write-through visible on the bus in the same cycle
    task automatic store_line(mem_bus_pkg::addr_t addr, mem_bus_pkg::line_data_t data);
        @(negedge clock);
        load_en    = 1'b0;
        store_en   = 1'b1;
        store_addr = addr;
        store_data = data;
        @(posedge clock);
        queue_check({test_name, " store command"}, 64'(mem_bus_pkg::bus_store),
                    64'(mem_command));
        queue_check({test_name, " store addr"}, 64'({addr[31:3], 3'b000}), 64'(mem_addr));
        queue_check({test_name, " store data"}, data, mem_write_data);
        shadow_mem[addr[mem_bus_pkg::mem_addr_bits-1:mem_bus_pkg::line_offset_bits]] = data;
        shadow_valid[index_of(addr)] = 1'b1;
        shadow_tag[index_of(addr)]   = tag_of(addr);
    endtask

    // hold a load until load_valid and match its first cycle against the predicted hit
    task automatic load_line(mem_bus_pkg::addr_t addr);
        logic expect_hit;
        int   waited;
        expect_hit = predict_hit(addr);
        waited     = 0;
        @(negedge clock);
        store_en  = 1'b0;
        load_en   = 1'b1;
        load_addr = addr;
        @(posedge clock);
        queue_check({test_name, " hit"}, 64'(expect_hit), 64'(load_valid));
        queue_check({test_name, " command"},
                    expect_hit ? 64'(mem_bus_pkg::bus_none) : 64'(mem_bus_pkg::bus_load),
                    64'(mem_command));
        while (!load_valid && waited < wait_limit) begin
            @(posedge clock);
            waited++;
        end
        if (!load_valid) begin
            timeout_count++;
            $display("timeout: load of address %h got no data after %0d cycles", addr, waited);
        end else begin
            shadow_valid[index_of(addr)] = 1'b1;
            shadow_tag[index_of(addr)]   = tag_of(addr);
        end
    endtask

    // load held for a few cycles only so the miss gets abandoned
    task automatic load_for(mem_bus_pkg::addr_t addr, int cycles);
        @(negedge clock);
        store_en  = 1'b0;
        load_en   = 1'b1;
        load_addr = addr;
        repeat (cycles) @(posedge clock);
    endtask

    initial begin
        reset          = 1'b1;
        store_en       = 1'b0;
        store_addr     = '0;
        store_data     = '0;
        load_en        = 1'b0;
        load_addr      = '0;
        refuse_percent = 25;
        seed           = random_seed;
        check_count    = 0;
        error_count    = 0;
        timeout_count  = 0;
        test_name      = "reset";
        for (int i = 0; i < mem_lines; i++) begin
            shadow_mem[i] = line_pattern(i);
        end
        for (int i = 0; i < dcache_pkg::cache_lines; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_name = "reset_miss";
        load_line(32'h0000_0148);

        // load of the stored line follows in the very next cycle
        test_name = "store_load";
        store_line(32'h0000_1235, 64'h0123_4567_89ab_cdef);
        load_line(32'h0000_1230);

        test_name = "repeat_load";
        load_line(32'h0000_2468);
        load_line(32'h0000_246c);

        // two tags fighting for line 17
        test_name = "conflict";
        repeat (3) begin
            load_line(32'h0000_3188);
            load_line(32'h0000_5c88);
        end

        test_name = "back_pressure";
        @(negedge clock);
        refuse_percent = 85;
        for (int i = 0; i < 16; i++) begin
            rand_addr = $random(seed);
            if (i % 4 == 3) begin
                store_line(rand_addr, {$random(seed), $random(seed)});
            end else begin
                load_line(rand_addr);
            end
        end

        // the first miss on line 20 returns after the switch and must be ignored
        test_name = "abandon";
        @(negedge clock);
        refuse_percent = 0;
        load_for(32'h0000_21a0, 2);
        load_line(32'h0000_43a0);
        load_line(32'h0000_21a0);

        @(negedge clock);
        load_en  = 1'b0;
        store_en = 1'b0;
        repeat (4) @(posedge clock);

        $display("checks %0d errors %0d timeouts %0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
hw/mem_bus_pkg.sv
hw/dcache_pkg.sv
hw/dcache_request_select.sv
hw/dcache_line_store.sv
hw/dcache_miss_tracker.sv
hw/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// File: Makefile
# Verilator build and run of the data cache testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module dcache_tb \
		-Mdir obj_dir -o dcache_tb

# pass only when the simulation output holds the pass message
run: compile
	@out="$$(./obj_dir/dcache_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL TESTS PASSED$$"

clean:
	rm -rf obj_dir
